// File: hdl/jvs_frame_parser.sv
`timescale 1ns/1ps
// JVS execute stage
// Parses NODE, LENGTH, DATA and CHECKSUM after each sync mark, writes
// the payload out, checks the modulo-256 sum and counts good frames
// and checksum errors
module jvs_frame_parser (
    input  logic                             clk_sys,
    input  logic                             reset,
    input  logic [jvs_proto_pkg::BYTE_W-1:0] i_data,
    input  logic                             i_valid,
    input  logic                             i_sync,
    input  logic                             i_esc_err,
    output logic [jvs_proto_pkg::BYTE_W-1:0] o_node,
    output logic [jvs_proto_pkg::ADDR_W-1:0] o_length,
    output logic                             o_wr_en,
    output logic [jvs_proto_pkg::ADDR_W-1:0] o_wr_addr,
    output logic [jvs_proto_pkg::BYTE_W-1:0] o_wr_data,
    output logic                             o_frame_ok,
    output logic                             o_frame_err,
    output logic [jvs_proto_pkg::CNT_W-1:0]  o_frames_ok,
    output logic [jvs_proto_pkg::CNT_W-1:0]  o_checksum_errors
);
    import jvs_proto_pkg::*;

    localparam logic [2:0] ST_IDLE     = 3'd0;
    localparam logic [2:0] ST_NODE     = 3'd1;
    localparam logic [2:0] ST_LENGTH   = 3'd2;
    localparam logic [2:0] ST_DATA     = 3'd3;
    localparam logic [2:0] ST_CHECKSUM = 3'd4;

    logic [2:0]        state;
    logic [BYTE_W-1:0] sum;       // Node + length + data so far
    logic [ADDR_W-1:0] data_idx;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state             <= ST_IDLE;
            sum               <= '0;
            o_wr_en           <= 1'b0;
            o_frame_ok        <= 1'b0;
            o_frame_err       <= 1'b0;
            o_frames_ok       <= '0;
            o_checksum_errors <= '0;
        end else begin
            o_wr_en     <= 1'b0;
            o_frame_ok  <= 1'b0;
            o_frame_err <= 1'b0;
            if (i_sync) begin
                state <= ST_NODE;  // Any open frame is dropped quietly
            end else if (i_esc_err) begin
                if (state != ST_IDLE) o_frame_err <= 1'b1;
                state <= ST_IDLE;
            end else if (i_valid) begin
                case (state)
                    ST_NODE: begin
                        o_node <= i_data;
                        sum    <= i_data;
                        state  <= ST_LENGTH;
                    end
                    ST_LENGTH: begin
                        if (i_data == '0) begin
                            o_frame_err <= 1'b1;  // Empty frame is malformed
                            state       <= ST_IDLE;
                        end else begin
                            o_length <= i_data;
                            sum      <= sum + i_data;
                            data_idx <= '0;
                            state    <= ST_DATA;
                        end
                    end
                    ST_DATA: begin
                        o_wr_en   <= 1'b1;
                        o_wr_addr <= data_idx;
                        o_wr_data <= i_data;
                        sum       <= sum + i_data;
                        data_idx  <= data_idx + 1'b1;
                        if (data_idx == o_length - 1'b1) state <= ST_CHECKSUM;
                    end
                    ST_CHECKSUM: begin
                        if (sum == i_data) begin
                            o_frame_ok  <= 1'b1;
                            o_frames_ok <= o_frames_ok + 1'b1;
                        end else begin
                            o_frame_err       <= 1'b1;
                            o_checksum_errors <= o_checksum_errors + 1'b1;
                        end
                        state <= ST_IDLE;
                    end
                    default: state <= ST_IDLE;  // Bytes outside a frame
                endcase
            end
        end
    end

endmodule

// File: hdl/jvs_phy_pkg.sv
// JVS physical layer definitions
// UART character format and baud divisor width
package jvs_phy_pkg;

    // Clock cycles per bit, set at run time
    localparam int BAUD_DIV_W = 16;

    // 8N1 framing
    localparam int DATA_BITS = 8;

endpackage

// File: hdl/jvs_proto_pkg.sv
// JVS protocol definitions
// Frame control codes, escape codes and payload size limits shared by
// the receive chain and its testbench
package jvs_proto_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Control codes on the wire
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0] JVS_SYNC     = 8'hE0;  // Frame start, never escaped data
    localparam logic [7:0] JVS_ESCAPE   = 8'hD0;  // Escape marker
    localparam logic [7:0] JVS_ESC_SYNC = 8'hDF;  // D0 DF stands for E0
    localparam logic [7:0] JVS_ESC_ESC  = 8'hCF;  // D0 CF stands for D0

    ////////////////////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int BYTE_W      = 8;
    localparam int MAX_PAYLOAD = 255;  // LENGTH is one byte
    localparam int ADDR_W      = 8;    // Payload index and length
    localparam int CNT_W       = 8;    // Frame counters wrap

endpackage

// File: hdl/jvs_rx_buffer.sv
`timescale 1ns/1ps
// JVS result stage
// Payload memory written by the parser. After a good frame it shows
// byte 0 and the count of bytes left, then steps on each read strobe.
module jvs_rx_buffer (
    input  logic                             clk_sys,
    input  logic                             reset,
    input  logic                             i_wr_en,
    input  logic [jvs_proto_pkg::ADDR_W-1:0] i_wr_addr,
    input  logic [jvs_proto_pkg::BYTE_W-1:0] i_wr_data,
    input  logic                             i_frame_ok,
    input  logic [jvs_proto_pkg::ADDR_W-1:0] i_length,
    input  logic                             i_rx_next,
    output logic [jvs_proto_pkg::BYTE_W-1:0] o_rx_byte,
    output logic [jvs_proto_pkg::ADDR_W-1:0] o_rx_remaining,
    output logic                             o_rx_complete
);
    import jvs_proto_pkg::*;

    logic [BYTE_W-1:0] mem [0:MAX_PAYLOAD-1];
    logic [ADDR_W-1:0] rd_idx;
    logic [ADDR_W-1:0] rd_idx_next;

    assign rd_idx_next = rd_idx + 1'b1;

    always_ff @(posedge clk_sys) begin
        if (i_wr_en) mem[i_wr_addr] <= i_wr_data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sequential read port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rd_idx         <= '0;
            o_rx_remaining <= '0;
            o_rx_complete  <= 1'b0;
        end else begin
            o_rx_complete <= i_frame_ok;
            if (i_frame_ok) begin
                rd_idx         <= '0;
                o_rx_byte      <= mem[0];
                o_rx_remaining <= i_length - 1'b1;  // Zero means last byte shown
            end else if (i_rx_next && o_rx_remaining != '0) begin
                rd_idx         <= rd_idx_next;
                o_rx_byte      <= mem[rd_idx_next];
                o_rx_remaining <= o_rx_remaining - 1'b1;
            end
        end
    end

endmodule

// File: hdl/jvs_rx_top.sv
`timescale 1ns/1ps
// JVS receive top level
// UART receiver, escape decoder, frame parser and payload buffer in a
// straight chain with no back-pressure
module jvs_rx_top (
    input  logic                               clk_sys,
    input  logic                               reset,
    input  logic                               i_uart_rx,
    input  logic [jvs_phy_pkg::BAUD_DIV_W-1:0] i_baud_div,
    input  logic                               i_rx_next,
    output logic [jvs_proto_pkg::BYTE_W-1:0]   o_rx_byte,
    output logic [jvs_proto_pkg::ADDR_W-1:0]   o_rx_remaining,
    output logic [jvs_proto_pkg::BYTE_W-1:0]   o_src_node,
    output logic                               o_rx_complete,
    output logic                               o_rx_error,
    output logic [jvs_proto_pkg::CNT_W-1:0]    o_frames_ok,
    output logic [jvs_proto_pkg::CNT_W-1:0]    o_checksum_errors
);
    import jvs_proto_pkg::*;

    logic [BYTE_W-1:0] raw_byte;
    logic              raw_valid;
    logic [BYTE_W-1:0] dec_data;
    logic              dec_valid;
    logic              dec_sync;
    logic              dec_esc_err;
    logic [ADDR_W-1:0] frame_length;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [BYTE_W-1:0] wr_data;
    logic              frame_ok;

    jvs_uart_rx jvs_uart_rx_inst (
        .clk_sys(clk_sys), .reset(reset), .i_rx(i_uart_rx), .i_baud_div(i_baud_div),
        .o_byte(raw_byte), .o_byte_valid(raw_valid)
    );

    jvs_unescape jvs_unescape_inst (
        .clk_sys(clk_sys), .reset(reset), .i_byte(raw_byte), .i_byte_valid(raw_valid),
        .o_data(dec_data), .o_valid(dec_valid), .o_sync(dec_sync), .o_esc_err(dec_esc_err)
    );

    jvs_frame_parser jvs_frame_parser_inst (
        .clk_sys(clk_sys), .reset(reset), .i_data(dec_data), .i_valid(dec_valid),
        .i_sync(dec_sync), .i_esc_err(dec_esc_err), .o_node(o_src_node),
        .o_length(frame_length), .o_wr_en(wr_en), .o_wr_addr(wr_addr),
        .o_wr_data(wr_data), .o_frame_ok(frame_ok), .o_frame_err(o_rx_error),
        .o_frames_ok(o_frames_ok), .o_checksum_errors(o_checksum_errors)
    );

    jvs_rx_buffer jvs_rx_buffer_inst (
        .clk_sys(clk_sys), .reset(reset), .i_wr_en(wr_en), .i_wr_addr(wr_addr),
        .i_wr_data(wr_data), .i_frame_ok(frame_ok), .i_length(frame_length),
        .i_rx_next(i_rx_next), .o_rx_byte(o_rx_byte), .o_rx_remaining(o_rx_remaining),
        .o_rx_complete(o_rx_complete)
    );

endmodule

// File: hdl/jvs_uart_rx.sv
`timescale 1ns/1ps
// JVS UART receiver
// Synchronizes the serial line, finds the start edge and samples each
// bit at its middle using a run-time baud divisor. Delivers 8N1 bytes
// and drops any character whose stop bit reads low.
module jvs_uart_rx (
    input  logic                               clk_sys,
    input  logic                               reset,
    input  logic                               i_rx,
    input  logic [jvs_phy_pkg::BAUD_DIV_W-1:0] i_baud_div,
    output logic [jvs_proto_pkg::BYTE_W-1:0]   o_byte,
    output logic                               o_byte_valid
);
    import jvs_proto_pkg::*;
    import jvs_phy_pkg::*;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_DATA  = 2'd2;
    localparam logic [1:0] ST_STOP  = 2'd3;
    localparam int         BIT_IDX_W = $clog2(DATA_BITS);

    logic                  rx_meta;
    logic                  rx_sync;
    logic                  rx_prev;   // For falling edge
    logic [1:0]            state;
    logic [BAUD_DIV_W-1:0] baud_cnt;
    logic [BIT_IDX_W-1:0]  bit_idx;
    logic                  tick;

    assign tick = (baud_cnt == '0);  // Middle of the current bit

    // Line idles high
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bit sampling FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state        <= ST_IDLE;
            baud_cnt     <= '0;
            bit_idx      <= '0;
            o_byte_valid <= 1'b0;
        end else begin
            o_byte_valid <= 1'b0;
            if (!tick) baud_cnt <= baud_cnt - 1'b1;
            case (state)
                ST_IDLE: begin
                    if (rx_prev && !rx_sync) begin
                        baud_cnt <= i_baud_div >> 1;  // Half a bit to the middle
                        state    <= ST_START;
                    end
                end
                ST_START: begin
                    if (tick) begin
                        baud_cnt <= i_baud_div - 1'b1;
                        bit_idx  <= '0;
                        state    <= rx_sync ? ST_IDLE : ST_DATA;  // Glitch check
                    end
                end
                ST_DATA: begin
                    if (tick) begin
                        o_byte   <= {rx_sync, o_byte[BYTE_W-1:1]};  // LSB first
                        baud_cnt <= i_baud_div - 1'b1;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == BIT_IDX_W'(DATA_BITS - 1)) state <= ST_STOP;
                    end
                end
                default: begin
                    if (tick) begin
                        o_byte_valid <= rx_sync;  // Low stop bit drops the byte
                        state        <= ST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: hdl/jvs_unescape.sv
`timescale 1ns/1ps
// JVS decode stage
// Turns the raw byte stream into sync marks and decoded bytes.
// D0 DF becomes E0 and D0 CF becomes D0; any other pair is an error.
module jvs_unescape (
    input  logic                             clk_sys,
    input  logic                             reset,
    input  logic [jvs_proto_pkg::BYTE_W-1:0] i_byte,
    input  logic                             i_byte_valid,
    output logic [jvs_proto_pkg::BYTE_W-1:0] o_data,
    output logic                             o_valid,
    output logic                             o_sync,
    output logic                             o_esc_err
);
    import jvs_proto_pkg::*;

    logic esc_mode;  // Previous byte was D0

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            esc_mode  <= 1'b0;
            o_valid   <= 1'b0;
            o_sync    <= 1'b0;
            o_esc_err <= 1'b0;
        end else begin
            o_valid   <= 1'b0;
            o_sync    <= 1'b0;
            o_esc_err <= 1'b0;
            if (i_byte_valid) begin
                if (i_byte == JVS_SYNC) begin
                    // Raw sync always wins, even right after a marker
                    o_sync   <= 1'b1;
                    esc_mode <= 1'b0;
                end else if (esc_mode) begin
                    esc_mode <= 1'b0;
                    if (i_byte == JVS_ESC_SYNC) begin
                        o_data  <= JVS_SYNC;
                        o_valid <= 1'b1;
                    end else if (i_byte == JVS_ESC_ESC) begin
                        o_data  <= JVS_ESCAPE;
                        o_valid <= 1'b1;
                    end else begin
                        o_esc_err <= 1'b1;
                    end
                end else if (i_byte == JVS_ESCAPE) begin
                    esc_mode <= 1'b1;  // Wait for the code byte
                end else begin
                    o_data  <= i_byte;
                    o_valid <= 1'b1;
                end
            end
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the JVS receive testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_jvs_rx -f sim.f -o sim_jvs_rx
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_jvs_rx)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// File: sim.f
+incdir+include
hdl/jvs_proto_pkg.sv
hdl/jvs_phy_pkg.sv
hdl/jvs_uart_rx.sv
hdl/jvs_unescape.sv
hdl/jvs_frame_parser.sv
hdl/jvs_rx_buffer.sv
hdl/jvs_rx_top.sv
testbench/tb_jvs_rx.sv

// File: include/jvs_tb_model.svh
// JVS testbench model
// LFSR stepping, frame checksum, escaping of a frame onto the wire and
// 8N1 serial bit driving
`ifndef JVS_TB_MODEL_SVH
`define JVS_TB_MODEL_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Modulo-256 sum of node, length and payload
function automatic logic [7:0] jvs_checksum(input logic [7:0] node, ref logic [7:0] pl[$]);
    logic [7:0] sum;
    sum = node + 8'(pl.size());
    foreach (pl[i]) sum += pl[i];
    return sum;
endfunction

// Append one byte to the wire, escaped where needed
function automatic void jvs_push_escaped(ref logic [7:0] wire_q[$], input logic [7:0] b);
    if (b == jvs_proto_pkg::JVS_SYNC) begin
        wire_q.push_back(jvs_proto_pkg::JVS_ESCAPE);
        wire_q.push_back(jvs_proto_pkg::JVS_ESC_SYNC);
    end else if (b == jvs_proto_pkg::JVS_ESCAPE) begin
        wire_q.push_back(jvs_proto_pkg::JVS_ESCAPE);
        wire_q.push_back(jvs_proto_pkg::JVS_ESC_ESC);
    end else begin
        wire_q.push_back(b);
    end
endfunction

// One character with start, 8 data, stop and an idle bit
task automatic uart_drive_byte(ref logic line, input logic [7:0] b, input realtime bit_t);
    line = 1'b0;
    #(bit_t);
    for (int i = 0; i < 8; i++) begin
        line = b[i];
        #(bit_t);
    end
    line = 1'b1;
    #(2 * bit_t);
endtask

`endif

// File: testbench/tb_jvs_rx.sv
`timescale 1ns/1ps
// JVS receive testbench
// Sends random frames over the serial line at two baud divisors and checks
// readback, node, counters and the error paths against a testbench model
module tb_jvs_rx;
    import jvs_proto_pkg::*;
    import jvs_phy_pkg::*;

    `include "jvs_tb_model.svh"

    localparam logic [31:0]           SEED        = 32'hfe0d0d72;
    localparam int                    NUM_FRAMES  = 26;  // Over all tests
    localparam int                    MAX_LEN     = 16;
    localparam logic [BAUD_DIV_W-1:0] DIV_FAST    = 16'd8;
    localparam logic [BAUD_DIV_W-1:0] DIV_SLOW    = 16'd13;
    localparam realtime               WATCHDOG_NS =
        NUM_FRAMES * (2 * MAX_LEN + 8) * 10 * DIV_SLOW * 4.0 * 2;

    logic                  clk_sys;
    logic                  reset;
    logic                  uart_rx;
    logic [BAUD_DIV_W-1:0] baud_div;
    logic                  rx_next;
    logic [BYTE_W-1:0]     rx_byte;
    logic [ADDR_W-1:0]     rx_remaining;
    logic [BYTE_W-1:0]     src_node;
    logic                  rx_complete;
    logic                  rx_error;
    logic [CNT_W-1:0]      frames_ok;
    logic [CNT_W-1:0]      checksum_errors;

    logic [31:0]      lfsr_state;
    logic [CNT_W-1:0] exp_frames;     // Model of the good-frame counter
    logic [CNT_W-1:0] exp_cs_errors;  // Model of the checksum-error counter
    int               ok_seen;
    int               err_seen;
    int               ok_base;
    int               err_base;
    int               checks;
    int               errors;
    int               test_errors;

    jvs_rx_top jvs_rx_top_inst (
        .clk_sys(clk_sys), .reset(reset), .i_uart_rx(uart_rx), .i_baud_div(baud_div),
        .i_rx_next(rx_next), .o_rx_byte(rx_byte), .o_rx_remaining(rx_remaining),
        .o_src_node(src_node), .o_rx_complete(rx_complete), .o_rx_error(rx_error),
        .o_frames_ok(frames_ok), .o_checksum_errors(checksum_errors)
    );

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    // Result strobes counted away from the active edge
    always @(negedge clk_sys) begin
        if (!reset) begin
            if (rx_complete) ok_seen++;
            if (rx_error) err_seen++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("sim failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};  // One step per bit
        end
        return r;
    endfunction

    function automatic logic [7:0] rand_plain_byte();
        logic [7:0] b;
        do b = 8'(rand_bits(8)); while (b == JVS_SYNC || b == JVS_ESCAPE);
        return b;
    endfunction

    task automatic make_payload(ref logic [7:0] pl[$], input int len, input bit plain);
        pl.delete();
        for (int i = 0; i < len; i++) pl.push_back(plain ? rand_plain_byte() : 8'(rand_bits(8)));
    endtask

    task automatic append_frame(ref logic [7:0] wire_q[$], input logic [7:0] node,
                                ref logic [7:0] pl[$], input logic [7:0] cs_add);
        wire_q.push_back(JVS_SYNC);  // Only raw code on the wire
        jvs_push_escaped(wire_q, node);
        jvs_push_escaped(wire_q, 8'(pl.size()));
        foreach (pl[i]) jvs_push_escaped(wire_q, pl[i]);
        jvs_push_escaped(wire_q, jvs_checksum(node, pl) + cs_add);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (exp == act) else begin
            $display("ERR %s expected %h got %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_cond(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            test_errors++;
        end
    endtask

    task automatic drive_and_wait(ref logic [7:0] wire_q[$]);
        int waited;
        ok_base  = ok_seen;
        err_base = err_seen;
        @(posedge clk_sys);
        #1;
        foreach (wire_q[i]) uart_drive_byte(uart_rx, wire_q[i], baud_div * 4.0);
        waited = 0;
        while (ok_seen == ok_base && err_seen == err_base && waited < 40 * int'(baud_div)) begin
            @(posedge clk_sys);
            #1;
            waited++;
        end
        check_cond(ok_seen != ok_base || err_seen != err_base,
                   "no frame result strobe after the last character");
        repeat (4) @(posedge clk_sys);  // Room for a stray second strobe
        #1;
    endtask

    task automatic expect_good(input logic [7:0] node, ref logic [7:0] pl[$]);
        exp_frames++;
        check_value("o_rx_complete pulses", 32'd1, 32'(ok_seen - ok_base));
        check_value("o_rx_error pulses", 32'd0, 32'(err_seen - err_base));
        check_value("o_src_node", 32'(node), 32'(src_node));
        check_value("o_frames_ok", 32'(exp_frames), 32'(frames_ok));
        check_value("o_checksum_errors", 32'(exp_cs_errors), 32'(checksum_errors));
        for (int k = 0; k < pl.size(); k++) begin
            if (k > 0) begin
                @(posedge clk_sys);
                #1 rx_next = 1'b1;
                @(posedge clk_sys);
                #1 rx_next = 1'b0;
            end
            check_value("o_rx_byte", 32'(pl[k]), 32'(rx_byte));
            check_value("o_rx_remaining", 32'(pl.size() - 1 - k), 32'(rx_remaining));
        end
    endtask

    task automatic expect_error(input bit cs_inc);
        if (cs_inc) exp_cs_errors++;
        check_value("o_rx_complete pulses", 32'd0, 32'(ok_seen - ok_base));
        check_value("o_rx_error pulses", 32'd1, 32'(err_seen - err_base));
        check_value("o_frames_ok", 32'(exp_frames), 32'(frames_ok));
        check_value("o_checksum_errors", 32'(exp_cs_errors), 32'(checksum_errors));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_clean(input int n);
        logic [7:0] wire_q[$];
        logic [7:0] pl[$];
        logic [7:0] node;
        for (int f = 0; f < n; f++) begin
            node = rand_plain_byte();
            make_payload(pl, 1 + int'(rand_bits(4)), 1'b1);
            wire_q.delete();
            append_frame(wire_q, node, pl, 8'h00);
            drive_and_wait(wire_q);
            expect_good(node, pl);
        end
    endtask

    task automatic run_escaped();
        logic [7:0] wire_q[$];
        logic [7:0] pl[$];
        logic [7:0] node;
        int         last;
        for (int f = 0; f < 4; f++) begin
            node = (f == 0) ? JVS_SYNC : (f == 1) ? JVS_ESCAPE : rand_plain_byte();
            make_payload(pl, 1 + int'(rand_bits(4)), 1'b0);
            for (int k = 0; k < pl.size(); k += 2) pl[k] = rand_bits(1) ? JVS_SYNC : JVS_ESCAPE;
            if (f >= 2) begin
                // Last byte picked so that the checksum itself needs escaping
                last     = pl.size() - 1;
                pl[last] = 8'h00;
                pl[last] = ((f == 2) ? JVS_SYNC : JVS_ESCAPE) - jvs_checksum(node, pl);
            end
            wire_q.delete();
            append_frame(wire_q, node, pl, 8'h00);
            drive_and_wait(wire_q);
            expect_good(node, pl);
        end
    endtask

    task automatic run_bad_checksum(input int n);
        logic [7:0] wire_q[$];
        logic [7:0] pl[$];
        logic [7:0] cs_add;
        for (int f = 0; f < n; f++) begin
            make_payload(pl, 1 + int'(rand_bits(4)), 1'b1);
            do cs_add = 8'(rand_bits(8)); while (cs_add == 8'h00);
            wire_q.delete();
            append_frame(wire_q, rand_plain_byte(), pl, cs_add);
            drive_and_wait(wire_q);
            expect_error(1'b1);
        end
    endtask

    task automatic run_resync();
        logic [7:0] wire_q[$];
        logic [7:0] pl[$];
        logic [7:0] node;
        logic [7:0] bad;
        // Raw sync three bytes into an eight byte payload
        wire_q.push_back(JVS_SYNC);
        wire_q.push_back(rand_plain_byte());
        wire_q.push_back(8'd8);
        repeat (3) wire_q.push_back(rand_plain_byte());
        node = rand_plain_byte();
        make_payload(pl, 1 + int'(rand_bits(4)), 1'b1);
        append_frame(wire_q, node, pl, 8'h00);
        drive_and_wait(wire_q);
        expect_good(node, pl);

        do bad = 8'(rand_bits(8));
        while (bad == JVS_ESC_SYNC || bad == JVS_ESC_ESC || bad == JVS_SYNC);
        wire_q.delete();
        wire_q.push_back(JVS_SYNC);
        wire_q.push_back(rand_plain_byte());
        wire_q.push_back(8'd4);
        wire_q.push_back(JVS_ESCAPE);  // Invalid pair in the payload
        wire_q.push_back(bad);
        drive_and_wait(wire_q);
        expect_error(1'b0);

        wire_q.delete();
        wire_q.push_back(JVS_SYNC);
        wire_q.push_back(rand_plain_byte());
        wire_q.push_back(8'h00);  // Empty frame
        drive_and_wait(wire_q);
        expect_error(1'b0);
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, test_errors);
        errors      += test_errors;
        test_errors  = 0;
    endtask

    initial begin
        lfsr_state    = SEED;
        reset         = 1'b1;
        uart_rx       = 1'b1;  // Idle line
        rx_next       = 1'b0;
        baud_div      = DIV_FAST;
        exp_frames    = '0;
        exp_cs_errors = '0;
        ok_seen       = 0;
        err_seen      = 0;
        checks        = 0;
        errors        = 0;
        test_errors   = 0;
        repeat (10) @(posedge clk_sys);
        #1 reset = 1'b0;
        repeat (4) @(posedge clk_sys);

        run_clean(6);
        finish_test(1, "clean frames");
        run_escaped();
        finish_test(2, "escaped bytes");
        run_bad_checksum(3);
        finish_test(3, "bad checksum");
        run_resync();
        finish_test(4, "resync and format errors");
        @(posedge clk_sys);
        #1 baud_div = DIV_SLOW;
        run_clean(6);
        run_bad_checksum(3);
        finish_test(5, "baud change");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
